//--- flist.f
+incdir+design
design/dem_uart_pkg.sv
design/dem_uart_bus_decode.sv
design/dem_uart_regs.sv
design/dem_uart_rx_router.sv
design/dem_uart_tx_arbiter.sv
design/dem_uart_top.sv
verif/dem_uart_assert.sv
verif/dem_uart_tb.sv

//--- run.sh
#!/bin/sh
# Build the debug UART testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dem_uart_tb \
  -f flist.f -o dem_uart_sim || { echo "Build failed"; exit 1; }

out="$(./obj_dir/dem_uart_sim)"
echo "$out"

echo "$out" | grep -qx "No errors" && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}

//--- verif/dem_uart_tb.sv
// Testbench for the debug UART top level
// Runs a table of host accesses, flit injections and expected output flits,
// comparing each response with values built from the 16550 register map
`timescale 1ns/10ps
`include "dem_uart_defs.svh"

module dem_uart_tb;

  localparam int TIMEOUT = 200;

  // Step kinds
  localparam logic [2:0] OP_WR    = 3'd0;
  localparam logic [2:0] OP_RD    = 3'd1;
  localparam logic [2:0] OP_FLIT  = 3'd2;
  localparam logic [2:0] OP_READY = 3'd3;
  localparam logic [2:0] OP_OUT   = 3'd4;
  localparam logic [2:0] OP_QUIET = 3'd5;
  localparam logic [2:0] OP_BUSY  = 3'd6;
  localparam logic [2:0] OP_IRQ   = 3'd7;

  // Short names for the register offsets
  localparam logic [2:0] THR = `DEM_UART_REG_RBR_THR;
  localparam logic [2:0] IER = `DEM_UART_REG_IER;
  localparam logic [2:0] IIR = `DEM_UART_REG_IIR_FCR;
  localparam logic [2:0] LCR = `DEM_UART_REG_LCR;
  localparam logic [2:0] LSR = `DEM_UART_REG_LSR;

  // One table entry, data and exp meaning depend on op
  typedef struct packed {
    logic [2:0]                  op;
    logic [`DEM_UART_ADDR_W-1:0] addr;
    logic [17:0]                 data;
    logic [17:0]                 exp;
  } step_t;

  logic                          clk = 1'b0;
  logic                          rst;
  dem_uart_pkg::host_req_t       host_req;
  dem_uart_pkg::host_rsp_t       host_rsp;
  dem_uart_pkg::dii_flit_t       in_flit;
  logic                          in_flit_valid;
  logic                          in_flit_ready;
  dem_uart_pkg::dii_flit_t       out_flit;
  logic                          out_flit_valid;
  logic                          out_flit_ready;
  logic [`DEM_UART_CHANNELS-1:0] irq_out;

  step_t                   steps[$];
  string                   names[$];
  dem_uart_pkg::dii_flit_t seen[$];
  logic [31:0]             lcg_state = 32'he33f;
  int                      errors = 0;
  int                      timeouts = 0;

  dem_uart_top UUT (
    .clk, .rst, .host_req, .host_rsp, .in_flit, .in_flit_valid, .in_flit_ready,
    .out_flit, .out_flit_valid, .out_flit_ready, .irq_out
  );

  always #10 clk = ~clk;

  // Every accepted output flit, in order of handshake
  always @(negedge clk) begin
    if (!rst && out_flit_valid && out_flit_ready) begin
      seen.push_back(out_flit);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Expected value helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [7:0] next_char();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  // Channel select above the register offset
  function automatic logic [`DEM_UART_ADDR_W-1:0] reg_loc(int chan, logic [2:0] off);
    return {`DEM_UART_CHAN_W'(chan), off};
  endfunction

  function automatic logic [17:0] char_flit(int chan, logic [7:0] ch);
    dem_uart_pkg::dii_flit_t f;
    f.kind                     = 1'b0;
    f.last                     = 1'b1;
    f.payload.char_w.channel   = 4'(chan);
    f.payload.char_w.reserved  = 4'h0;
    f.payload.char_w.character = ch;
    return f;
  endfunction

  // Drop control, arg bit 0 is the new flag
  function automatic logic [17:0] ctrl_flit(int chan, logic arg);
    dem_uart_pkg::dii_flit_t f;
    f.kind                  = 1'b1;
    f.last                  = 1'b1;
    f.payload.ctrl_w.channel = 4'(chan);
    f.payload.ctrl_w.opcode  = `DEM_UART_OP_DROP;
    f.payload.ctrl_w.arg     = {7'h00, arg};
    return f;
  endfunction

  // DR in bit 0, THRE and TEMT in bits 5 and 6
  function automatic logic [17:0] lsr_value(logic dr, logic thre);
    return {10'h000, 1'b0, thre, thre, 4'h0, dr};
  endfunction

  function automatic void add_step(string name, logic [2:0] op,
                                   logic [`DEM_UART_ADDR_W-1:0] addr,
                                   logic [17:0] data, logic [17:0] exp);
    steps.push_back('{op: op, addr: addr, data: data, exp: exp});
    names.push_back(name);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus and flit drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic host_access(input logic write, input logic [`DEM_UART_ADDR_W-1:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
    int cnt = 0;
    @(posedge clk);
    host_req <= '{req: 1'b1, write: write, addr: addr, wdata: wdata};
    @(posedge clk);
    host_req.req <= 1'b0;
    @(negedge clk);
    while (!host_rsp.ack && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    assert (cnt < TIMEOUT) else begin
      $display("Timeout: no host ack for address %h", addr);
      timeouts++;
    end
    rdata = host_rsp.rdata;
  endtask

  // Hold valid until the router takes the flit
  task automatic inject_flit(input logic [17:0] f);
    int cnt = 0;
    @(posedge clk);
    in_flit       <= f;
    in_flit_valid <= 1'b1;
    @(negedge clk);
    while (!in_flit_ready && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    assert (cnt < TIMEOUT) else begin
      $display("Timeout: receive flit %h was never accepted", f);
      timeouts++;
    end
    @(posedge clk);
    in_flit_valid <= 1'b0;
  endtask

  task automatic run_step(input int i);
    step_t       s;
    logic [7:0]  rdata;
    logic [17:0] got;
    int          cnt;
    s   = steps[i];
    cnt = 0;
    case (s.op)
      OP_WR: host_access(1'b1, s.addr, s.data[7:0], rdata);
      OP_RD: begin
        host_access(1'b0, s.addr, 8'h00, rdata);
        assert (rdata == s.exp[7:0]) else begin
          $display("** Error: %s expected %h actual %h", names[i], s.exp[7:0], rdata);
          errors++;
        end
      end
      OP_FLIT: inject_flit(s.data);
      OP_READY: begin
        @(posedge clk);
        out_flit_ready <= s.data[0];
      end
      OP_OUT: begin
        while (seen.size() == 0 && cnt < TIMEOUT) begin
          @(negedge clk);
          cnt++;
        end
        assert (seen.size() > 0) else begin
          $display("Timeout: no output flit arrived for %s", names[i]);
          timeouts++;
        end
        if (seen.size() > 0) begin
          got = seen.pop_front();
          assert (got == s.exp) else begin
            $display("** Error: %s expected %h actual %h", names[i], s.exp, got);
            errors++;
          end
        end
      end
      OP_QUIET: begin
        // Quiet window, nothing may come out
        repeat (8) @(negedge clk);
        assert (seen.size() == 0) else begin
          $display("** Error: %s expected 0 flits actual %0d", names[i], seen.size());
          errors++;
        end
        seen.delete();
      end
      OP_BUSY: begin
        // Offer a character to a full slot for one cycle
        @(posedge clk);
        in_flit       <= s.data;
        in_flit_valid <= 1'b1;
        @(negedge clk);
        assert (in_flit_ready == s.exp[0]) else begin
          $display("** Error: %s expected %b actual %b", names[i], s.exp[0], in_flit_ready);
          errors++;
        end
        @(posedge clk);
        in_flit_valid <= 1'b0;
      end
      default: begin
        while (irq_out != s.exp[`DEM_UART_CHANNELS-1:0] && cnt < TIMEOUT) begin
          @(negedge clk);
          cnt++;
        end
        assert (irq_out == s.exp[`DEM_UART_CHANNELS-1:0]) else begin
          $display("** Error: %s expected %b actual %b", names[i],
                   s.exp[`DEM_UART_CHANNELS-1:0], irq_out);
          errors++;
        end
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  function automatic void build_table();
    logic [7:0] ch [16];
    foreach (ch[n]) begin
      ch[n] = next_char();
    end
    // Readback, channel independence, DLAB banking
    add_step("lcr_reset", OP_RD, reg_loc(0, LCR), 0, 18'h00);
    add_step("lcr_write", OP_WR, reg_loc(1, LCR), 18'h1b, 0);
    add_step("lcr_read", OP_RD, reg_loc(1, LCR), 0, 18'h1b);
    add_step("lcr_other_chan", OP_RD, reg_loc(0, LCR), 0, 18'h00);
    add_step("ier_write", OP_WR, reg_loc(2, IER), 18'h05, 0);
    add_step("ier_read", OP_RD, reg_loc(2, IER), 0, 18'h05);
    add_step("ier_clear", OP_WR, reg_loc(2, IER), 18'h00, 0);
    add_step("dlab_set", OP_WR, reg_loc(3, LCR), 18'h80, 0);
    add_step("dll_write", OP_WR, reg_loc(3, THR), 18'(ch[0]), 0);
    add_step("dlm_write", OP_WR, reg_loc(3, IER), 18'(ch[1]), 0);
    add_step("dll_read", OP_RD, reg_loc(3, THR), 0, 18'(ch[0]));
    add_step("dlm_read", OP_RD, reg_loc(3, IER), 0, 18'(ch[1]));
    add_step("dll_no_flit", OP_QUIET, 0, 0, 0);
    add_step("dlab_clear", OP_WR, reg_loc(3, LCR), 18'h03, 0);
    add_step("lcr_after_dlab", OP_RD, reg_loc(3, LCR), 0, 18'h03);
    add_step("ier_after_dlab", OP_RD, reg_loc(3, IER), 0, 18'h00);
    // Transmit, then round robin from the channel after the last winner
    add_step("thr_single", OP_WR, reg_loc(1, THR), 18'(ch[2]), 0);
    add_step("flit_single", OP_OUT, 0, 0, char_flit(1, ch[2]));
    add_step("rr_stall", OP_READY, 0, 18'h0, 0);
    add_step("rr_thr_c2", OP_WR, reg_loc(2, THR), 18'(ch[3]), 0);
    add_step("rr_thr_c0", OP_WR, reg_loc(0, THR), 18'(ch[4]), 0);
    add_step("rr_thr_c3", OP_WR, reg_loc(3, THR), 18'(ch[5]), 0);
    add_step("rr_thr_c1", OP_WR, reg_loc(1, THR), 18'(ch[6]), 0);
    add_step("rr_release", OP_READY, 0, 18'h1, 0);
    add_step("rr_flit_c2", OP_OUT, 0, 0, char_flit(2, ch[3]));
    add_step("rr_flit_c3", OP_OUT, 0, 0, char_flit(3, ch[5]));
    add_step("rr_flit_c0", OP_OUT, 0, 0, char_flit(0, ch[4]));
    add_step("rr_flit_c1", OP_OUT, 0, 0, char_flit(1, ch[6]));
    add_step("rr_done", OP_QUIET, 0, 0, 0);
    // Receive, a second character waits while the slot is full
    add_step("rx_inject", OP_FLIT, 0, char_flit(0, ch[7]), 0);
    add_step("rx_lsr_ready", OP_RD, reg_loc(0, LSR), 0, lsr_value(1'b1, 1'b1));
    add_step("rx_slot_busy", OP_BUSY, 0, char_flit(0, ch[15]), 18'h0);
    add_step("rx_rbr", OP_RD, reg_loc(0, THR), 0, 18'(ch[7]));
    add_step("rx_lsr_empty", OP_RD, reg_loc(0, LSR), 0, lsr_value(1'b0, 1'b1));
    add_step("rx_bad_chan", OP_FLIT, 0, char_flit(5, ch[8]), 0);
    add_step("rx_bad_chan_lsr", OP_RD, reg_loc(1, LSR), 0, lsr_value(1'b0, 1'b1));
    // Interrupt identification
    add_step("iir_none", OP_RD, reg_loc(0, IIR), 0, 18'h01);
    add_step("irq_idle", OP_IRQ, 0, 0, 18'h0);
    add_step("etbei_set", OP_WR, reg_loc(1, IER), 18'h02, 0);
    add_step("iir_thre", OP_RD, reg_loc(1, IIR), 0, 18'h02);
    add_step("irq_thre", OP_IRQ, 0, 0, 18'b0010);
    add_step("etbei_clear", OP_WR, reg_loc(1, IER), 18'h00, 0);
    add_step("irq_thre_gone", OP_IRQ, 0, 0, 18'h0);
    add_step("rbf_inject", OP_FLIT, 0, char_flit(2, ch[9]), 0);
    add_step("erbfi_set", OP_WR, reg_loc(2, IER), 18'h01, 0);
    add_step("iir_rbf", OP_RD, reg_loc(2, IIR), 0, 18'h04);
    add_step("irq_rbf", OP_IRQ, 0, 0, 18'b0100);
    add_step("rbf_read", OP_RD, reg_loc(2, THR), 0, 18'(ch[9]));
    add_step("iir_rbf_gone", OP_RD, reg_loc(2, IIR), 0, 18'h01);
    add_step("erbfi_clear", OP_WR, reg_loc(2, IER), 18'h00, 0);
    add_step("irq_rbf_gone", OP_IRQ, 0, 0, 18'h0);
    // Drop on channel 3 only
    add_step("drop_on", OP_FLIT, 0, ctrl_flit(3, 1'b1), 0);
    add_step("drop_thr", OP_WR, reg_loc(3, THR), 18'(ch[10]), 0);
    add_step("drop_no_flit", OP_QUIET, 0, 0, 0);
    add_step("drop_other_thr", OP_WR, reg_loc(0, THR), 18'(ch[11]), 0);
    add_step("drop_other_flit", OP_OUT, 0, 0, char_flit(0, ch[11]));
    add_step("drop_off", OP_FLIT, 0, ctrl_flit(3, 1'b0), 0);
    add_step("undrop_thr", OP_WR, reg_loc(3, THR), 18'(ch[12]), 0);
    add_step("undrop_flit", OP_OUT, 0, 0, char_flit(3, ch[12]));
    // Back-pressure, the second write is lost
    add_step("bp_stall", OP_READY, 0, 18'h0, 0);
    add_step("bp_thr_first", OP_WR, reg_loc(1, THR), 18'(ch[13]), 0);
    add_step("bp_lsr_busy", OP_RD, reg_loc(1, LSR), 0, lsr_value(1'b0, 1'b0));
    add_step("bp_thr_lost", OP_WR, reg_loc(1, THR), 18'(ch[14]), 0);
    add_step("bp_release", OP_READY, 0, 18'h1, 0);
    add_step("bp_flit", OP_OUT, 0, 0, char_flit(1, ch[13]));
    add_step("bp_only_one", OP_QUIET, 0, 0, 0);
  endfunction

  initial begin
    rst            = 1'b1;
    host_req       = '0;
    in_flit        = '0;
    in_flit_valid  = 1'b0;
    out_flit_ready = 1'b1;
    build_table();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < steps.size(); i++) begin
      run_step(i);
    end
    repeat (4) @(posedge clk);
    $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verif/dem_uart_assert.sv
// Protocol checks on the debug UART top level ports
// Bound into dem_uart_top, watches the host response and output flits
`timescale 1ns/10ps

module dem_uart_assert (
  input logic                    clk,
  input logic                    rst,
  input dem_uart_pkg::host_req_t host_req,
  input dem_uart_pkg::host_rsp_t host_rsp,
  input dem_uart_pkg::dii_flit_t out_flit,
  input logic                    out_flit_valid,
  input logic                    out_flit_ready
);

  // Ack exactly one cycle after each request
  ack_after_req: assert property (@(posedge clk) disable iff (rst)
    host_req.req |=> host_rsp.ack)
    else $error("host ack missing one cycle after a request");

  // No request, no ack on the next cycle
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
    !host_req.req |=> !host_rsp.ack)
    else $error("host ack held without a new request");

  // Stalled flit must not change
  flit_stable: assert property (@(posedge clk) disable iff (rst)
    out_flit_valid && !out_flit_ready |=> out_flit_valid && $stable(out_flit))
    else $error("output flit changed or dropped while stalled");

  // Transmit side only sends characters
  flit_is_char: assert property (@(posedge clk) disable iff (rst)
    out_flit_valid |-> !out_flit.kind)
    else $error("output flit is not a character flit");

endmodule

bind dem_uart_top dem_uart_assert u_assert (
  .clk, .rst, .host_req, .host_rsp, .out_flit, .out_flit_valid, .out_flit_ready
);

//--- design/dem_uart_top.sv
// Top level of the debug UART subsystem
// Host register bus on one side, receive and transmit debug flits on
// the other, one 16550 register block per channel in between
`timescale 1ns/10ps
`include "dem_uart_defs.svh"

module dem_uart_top (
  input  logic                          clk,
  input  logic                          rst,
  input  dem_uart_pkg::host_req_t       host_req,
  output dem_uart_pkg::host_rsp_t       host_rsp,
  input  dem_uart_pkg::dii_flit_t       in_flit,
  input  logic                          in_flit_valid,
  output logic                          in_flit_ready,
  output dem_uart_pkg::dii_flit_t       out_flit,
  output logic                          out_flit_valid,
  input  logic                          out_flit_ready,
  output logic [`DEM_UART_CHANNELS-1:0] irq_out
);

  // Bus side
  logic [`DEM_UART_CHANNELS-1:0]      reg_req;
  logic                               reg_write;
  logic [2:0]                         reg_addr;
  logic [7:0]                         reg_wdata;
  logic [`DEM_UART_CHANNELS-1:0][7:0] reg_rdata;
  logic [`DEM_UART_CHANNELS-1:0]      irq;

  // Character paths
  logic [`DEM_UART_CHANNELS-1:0]      rx_take, rx_valid;
  logic [`DEM_UART_CHANNELS-1:0][7:0] rx_char;
  logic [`DEM_UART_CHANNELS-1:0]      tx_valid, tx_ready;
  logic [`DEM_UART_CHANNELS-1:0][7:0] tx_char;
  logic [`DEM_UART_CHANNELS-1:0]      drop;

  dem_uart_bus_decode u_decode (
    .clk, .rst, .host_req, .host_rsp,
    .reg_req, .reg_write, .reg_addr, .reg_wdata, .reg_rdata,
    .irq, .irq_out
  );

  dem_uart_rx_router u_rx_router (
    .clk, .rst, .in_flit, .in_flit_valid, .in_flit_ready,
    .rx_take, .rx_valid, .rx_char, .drop
  );

  ////////////////////////////////////////////////////////////////////////////
  // Per-channel 16550 register blocks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar c = 0; c < `DEM_UART_CHANNELS; c++) begin : g_chan
    dem_uart_regs u_regs (
      .clk, .rst,
      .reg_req   (reg_req[c]),
      .reg_write, .reg_addr, .reg_wdata,
      .reg_rdata (reg_rdata[c]),
      .drop      (drop[c]),
      .rx_valid  (rx_valid[c]),
      .rx_char   (rx_char[c]),
      .rx_take   (rx_take[c]),
      .tx_ready  (tx_ready[c]),
      .tx_valid  (tx_valid[c]),
      .tx_char   (tx_char[c]),
      .irq       (irq[c])
    );
  end

  dem_uart_tx_arbiter u_tx_arbiter (
    .clk, .rst, .tx_valid, .tx_char, .tx_ready, .drop,
    .out_flit, .out_flit_valid, .out_flit_ready
  );

endmodule

//--- design/dem_uart_tx_arbiter.sv
// Transmit arbiter
// Keeps one character per channel and turns them into character flits,
// serving full slots in round-robin order after the last winner
`timescale 1ns/10ps
`include "dem_uart_defs.svh"

module dem_uart_tx_arbiter (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [`DEM_UART_CHANNELS-1:0]      tx_valid,
  input  logic [`DEM_UART_CHANNELS-1:0][7:0] tx_char,
  output logic [`DEM_UART_CHANNELS-1:0]      tx_ready,
  input  logic [`DEM_UART_CHANNELS-1:0]      drop,
  output dem_uart_pkg::dii_flit_t            out_flit,
  output logic                               out_flit_valid,
  input  logic                               out_flit_ready
);

  logic [`DEM_UART_CHANNELS-1:0]      full;
  logic [`DEM_UART_CHANNELS-1:0][7:0] slot;
  logic [`DEM_UART_CHAN_W-1:0]        ptr;
  logic [`DEM_UART_CHAN_W-1:0]        pick_idx;
  logic [`DEM_UART_CHAN_W-1:0]        cand;
  logic                               pick_found;
  logic                               hold;
  logic [`DEM_UART_CHAN_W-1:0]        hold_idx;
  logic [`DEM_UART_CHAN_W-1:0]        grant;
  logic                               handshake;

  // Dropped channels always look ready, the write just vanishes
  assign tx_ready = ~full | drop;

  // Search from the slot after the last winner
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = ptr;
    cand       = ptr;
    for (int k = 1; k <= `DEM_UART_CHANNELS; k++) begin
      cand = `DEM_UART_CHAN_W'((int'(ptr) + k) % `DEM_UART_CHANNELS);
      if (!pick_found && full[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  // A stalled flit keeps its channel even if another slot fills
  assign grant          = hold ? hold_idx : pick_idx;
  assign out_flit_valid = hold | pick_found;
  assign handshake      = out_flit_valid & out_flit_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Outgoing flit, one character with last set
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    out_flit.kind                     = 1'b0;
    out_flit.last                     = 1'b1;
    out_flit.payload.char_w.channel   = 4'(grant);
    out_flit.payload.char_w.reserved  = 4'h0;
    out_flit.payload.char_w.character = slot[grant];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      full     <= '0;
      ptr      <= '0;
      hold     <= 1'b0;
      hold_idx <= '0;
    end else begin
      // Accept new characters into empty, non-dropped slots
      full <= full | (tx_valid & ~full & ~drop);
      if (handshake) begin
        full[grant] <= 1'b0;
        ptr         <= grant;
        hold        <= 1'b0;
      end else if (out_flit_valid) begin
        hold     <= 1'b1;
        hold_idx <= grant;
      end
    end
  end

  // Character storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < `DEM_UART_CHANNELS; i++) begin
      if (tx_valid[i] && !full[i] && !drop[i]) begin
        slot[i] <= tx_char[i];
      end
    end
  end

endmodule

//--- design/dem_uart_rx_router.sv
// Receive side flit router
// Character flits fill a one-entry slot per channel; control flits
// set the per-channel drop flags used on the transmit side
`timescale 1ns/10ps
`include "dem_uart_defs.svh"

module dem_uart_rx_router (
  input  logic                               clk,
  input  logic                               rst,
  input  dem_uart_pkg::dii_flit_t            in_flit,
  input  logic                               in_flit_valid,
  output logic                               in_flit_ready,
  input  logic [`DEM_UART_CHANNELS-1:0]      rx_take,
  output logic [`DEM_UART_CHANNELS-1:0]      rx_valid,
  output logic [`DEM_UART_CHANNELS-1:0][7:0] rx_char,
  output logic [`DEM_UART_CHANNELS-1:0]      drop
);

  logic [3:0]                  flit_chan;
  logic [`DEM_UART_CHAN_W-1:0] idx;
  logic                        in_range;
  logic                        accept;
  logic [`DEM_UART_CHANNELS-1:0] slot_full;

  // Channel field sits in the same bits in both payload views
  assign flit_chan = in_flit.payload.char_w.channel;
  assign idx       = flit_chan[`DEM_UART_CHAN_W-1:0];
  assign in_range  = flit_chan < `DEM_UART_CHANNELS;

  // Control and out-of-range flits never stall
  assign in_flit_ready = in_flit.kind | ~in_range | ~slot_full[idx];
  assign accept        = in_flit_valid & in_flit_ready;

  assign rx_valid = slot_full;

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_full <= '0;
      drop      <= '0;
    end else begin
      // RBR read empties the slot
      slot_full <= slot_full & ~rx_take;
      if (accept && in_range) begin
        if (!in_flit.kind) begin
          slot_full[idx] <= 1'b1;
        end else if (in_flit.payload.ctrl_w.opcode == `DEM_UART_OP_DROP) begin
          drop[idx] <= in_flit.payload.ctrl_w.arg[0];
        end
      end
    end
  end

  // Character storage
  always_ff @(posedge clk) begin
    if (accept && in_range && !in_flit.kind) begin
      rx_char[idx] <= in_flit.payload.char_w.character;
    end
  end

endmodule

//--- design/dem_uart_regs.sv
// 16550-style register file for one UART channel
// Answers host accesses in the same cycle; characters move through
// the rx_* and tx_* handshakes toward the flit router and arbiter
`timescale 1ns/10ps
`include "dem_uart_defs.svh"

module dem_uart_regs (
  input  logic       clk,
  input  logic       rst,
  input  logic       reg_req,
  input  logic       reg_write,
  input  logic [2:0] reg_addr,
  input  logic [7:0] reg_wdata,
  output logic [7:0] reg_rdata,
  input  logic       drop,
  input  logic       rx_valid,
  input  logic [7:0] rx_char,
  output logic       rx_take,
  input  logic       tx_ready,
  output logic       tx_valid,
  output logic [7:0] tx_char,
  output logic       irq
);

  // IIR interrupt identification codes
  localparam logic [3:0] IIR_NONE = 4'b0001;
  localparam logic [3:0] IIR_RBF  = 4'b0100;
  localparam logic [3:0] IIR_TBE  = 4'b0010;

  // LSR bit positions
  localparam int LSR_DR   = 0;
  localparam int LSR_THRE = 5;
  localparam int LSR_TEMT = 6;

  logic [7:0]  lcr, nxt_lcr;
  logic [15:0] divisor, nxt_divisor;
  logic        erbfi, etbei, elsi;
  logic        nxt_erbfi, nxt_etbei, nxt_elsi;
  logic        fifo_en, fifo_rx_clr, fifo_tx_clr, dma_mode;
  logic        nxt_fifo_en, nxt_fifo_rx_clr, nxt_fifo_tx_clr, nxt_dma_mode;
  logic        dlab;
  logic        irq_rbf, irq_tbe;

  // LCR bit 7 banks the divisor over offsets 0 and 1
  assign dlab = lcr[7];

  // Interrupt sources, no line errors in this model
  assign irq_rbf = erbfi & rx_valid;
  assign irq_tbe = etbei & (tx_ready | drop);
  assign irq     = irq_rbf | irq_tbe;

  always_ff @(posedge clk) begin
    if (rst) begin
      lcr         <= 8'h00;
      divisor     <= 16'h0000;
      {elsi, etbei, erbfi} <= 3'b000;
      {dma_mode, fifo_tx_clr, fifo_rx_clr, fifo_en} <= 4'h0;
    end else begin
      lcr         <= nxt_lcr;
      divisor     <= nxt_divisor;
      {elsi, etbei, erbfi} <= {nxt_elsi, nxt_etbei, nxt_erbfi};
      {dma_mode, fifo_tx_clr, fifo_rx_clr, fifo_en} <=
        {nxt_dma_mode, nxt_fifo_tx_clr, nxt_fifo_rx_clr, nxt_fifo_en};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register access decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_lcr = lcr;
    nxt_divisor = divisor;
    {nxt_elsi, nxt_etbei, nxt_erbfi} = {elsi, etbei, erbfi};
    {nxt_dma_mode, nxt_fifo_tx_clr, nxt_fifo_rx_clr, nxt_fifo_en} =
      {dma_mode, fifo_tx_clr, fifo_rx_clr, fifo_en};
    reg_rdata = 8'h00;
    rx_take   = 1'b0;
    tx_valid  = 1'b0;
    tx_char   = 8'h00;

    if (reg_req) begin
      case (reg_addr)
        `DEM_UART_REG_RBR_THR: begin
          if (dlab) begin
            // DLL
            if (reg_write) nxt_divisor[7:0] = reg_wdata;
            else reg_rdata = divisor[7:0];
          end else if (reg_write) begin
            // THR write, lost if the arbiter slot is busy
            tx_valid = 1'b1;
            tx_char  = reg_wdata;
          end else begin
            // RBR read frees the router slot
            reg_rdata = rx_char;
            rx_take   = 1'b1;
          end
        end
        `DEM_UART_REG_IER: begin
          if (dlab) begin
            // DLM
            if (reg_write) nxt_divisor[15:8] = reg_wdata;
            else reg_rdata = divisor[15:8];
          end else if (reg_write) begin
            {nxt_elsi, nxt_etbei, nxt_erbfi} = reg_wdata[2:0];
          end else begin
            reg_rdata = {5'b00000, elsi, etbei, erbfi};
          end
        end
        `DEM_UART_REG_IIR_FCR: begin
          if (reg_write) begin
            {nxt_dma_mode, nxt_fifo_tx_clr, nxt_fifo_rx_clr, nxt_fifo_en} = reg_wdata[3:0];
          end else begin
            reg_rdata[7:6] = {fifo_en, fifo_en};
            // Receive data outranks THR empty
            if (irq_rbf) reg_rdata[3:0] = IIR_RBF;
            else if (irq_tbe) reg_rdata[3:0] = IIR_TBE;
            else reg_rdata[3:0] = IIR_NONE;
          end
        end
        `DEM_UART_REG_LCR: begin
          if (reg_write) nxt_lcr = reg_wdata;
          else reg_rdata = lcr;
        end
        `DEM_UART_REG_LSR: begin
          reg_rdata[LSR_DR]   = rx_valid;
          reg_rdata[LSR_THRE] = tx_ready;
          reg_rdata[LSR_TEMT] = tx_ready;
        end
        default: reg_rdata = 8'h00;
      endcase
    end

    // Clear bits drop back one cycle later, nothing to flush
    if (fifo_en & fifo_rx_clr) nxt_fifo_rx_clr = 1'b0;
    if (fifo_en & fifo_tx_clr) nxt_fifo_tx_clr = 1'b0;
  end

endmodule

//--- design/dem_uart_bus_decode.sv
// Host bus decoder for the UART channels
// Steers each request to one register block and registers the answer,
// so the host sees ack and rdata exactly one cycle after req
`timescale 1ns/10ps
`include "dem_uart_defs.svh"

module dem_uart_bus_decode (
  input  logic                                clk,
  input  logic                                rst,
  input  dem_uart_pkg::host_req_t             host_req,
  output dem_uart_pkg::host_rsp_t             host_rsp,
  output logic [`DEM_UART_CHANNELS-1:0]       reg_req,
  output logic                                reg_write,
  output logic [2:0]                          reg_addr,
  output logic [7:0]                          reg_wdata,
  input  logic [`DEM_UART_CHANNELS-1:0][7:0]  reg_rdata,
  input  logic [`DEM_UART_CHANNELS-1:0]       irq,
  output logic [`DEM_UART_CHANNELS-1:0]       irq_out
);

  logic [`DEM_UART_CHAN_W-1:0] chan_sel;
  logic [7:0]                  sel_rdata;

  // Upper address bits pick the channel
  assign chan_sel = host_req.addr[`DEM_UART_ADDR_W-1:3];

  // Shared lines, only the strobe is per channel
  assign reg_write = host_req.write;
  assign reg_addr  = host_req.addr[2:0];
  assign reg_wdata = host_req.wdata;

  // One-hot strobe for the addressed channel
  always_comb begin
    reg_req = '0;
    for (int i = 0; i < `DEM_UART_CHANNELS; i++) begin
      if (host_req.req && (chan_sel == i)) begin
        reg_req[i] = 1'b1;
      end
    end
  end

  // Blocks drive zero when idle, still pick by strobe
  always_comb begin
    sel_rdata = 8'h00;
    for (int i = 0; i < `DEM_UART_CHANNELS; i++) begin
      if (reg_req[i]) begin
        sel_rdata = reg_rdata[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Response and interrupt registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      host_rsp.ack <= 1'b0;
      irq_out      <= '0;
    end else begin
      // Ack only for the cycle after each request
      host_rsp.ack <= host_req.req;
      irq_out      <= irq;
    end
  end

  always_ff @(posedge clk) begin
    host_rsp.rdata <= sel_rdata;
  end

endmodule

//--- design/dem_uart_pkg.sv
// Types shared by the debug UART blocks and their testbench
// Flit layout on the debug interconnect and the host register bus
`include "dem_uart_defs.svh"

package dem_uart_pkg;

  // Character view of a flit payload
  typedef struct packed {
    logic [3:0] channel;
    logic [3:0] reserved;
    logic [7:0] character;
  } dem_char_w_t;

  // Control view, same channel position
  typedef struct packed {
    logic [3:0] channel;
    logic [3:0] opcode;
    logic [7:0] arg;
  } dem_ctrl_w_t;

  // One 16-bit word, meaning picked by the flit kind bit
  typedef union packed {
    dem_char_w_t char_w;
    dem_ctrl_w_t ctrl_w;
  } dem_payload_u;

  // kind 0 is a character, kind 1 is control
  typedef struct packed {
    logic         kind;
    logic         last;
    dem_payload_u payload;
  } dii_flit_t;

  typedef struct packed {
    logic                        req;
    logic                        write;
    logic [`DEM_UART_ADDR_W-1:0] addr;
    logic [7:0]                  wdata;
  } host_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] rdata;
  } host_rsp_t;

endpackage

//--- design/dem_uart_defs.svh
// Shared constants for the debug UART subsystem
// Include wherever the channel count or a register offset is needed
`ifndef DEM_UART_DEFS_SVH
`define DEM_UART_DEFS_SVH

// Number of 16550 channels behind the host bus
`define DEM_UART_CHANNELS 4

// Channel select bits in the host address
`define DEM_UART_CHAN_W 2

// Register offsets within one channel
`define DEM_UART_REG_RBR_THR 3'd0
`define DEM_UART_REG_IER     3'd1
`define DEM_UART_REG_IIR_FCR 3'd2
`define DEM_UART_REG_LCR     3'd3
`define DEM_UART_REG_LSR     3'd5

// Control flit opcode, argument bit 0 sets the channel drop flag
`define DEM_UART_OP_DROP 4'd1

// Host address is channel select above a 3-bit register offset
`define DEM_UART_ADDR_W (`DEM_UART_CHAN_W + 3)

`endif
